//--- filereg_defs.svh
/*
 * constants for the register file, the mesh and the LBDR layout
 * operation word = {cmd, entry id, payload}, response = {node id, data}
 */
`ifndef FILEREG_DEFS_SVH
`define FILEREG_DEFS_SVH

// ----------------------------------------
// register file
`define FILEREG_NUM_ENTRIES     16
`define FILEREG_ENTRY_WIDTH     32
`define FILEREG_ENTRY_ID_WIDTH  4
`define FILEREG_CMD_WIDTH       1
`define FILEREG_OP_WIDTH        (`FILEREG_CMD_WIDTH + `FILEREG_ENTRY_ID_WIDTH + `FILEREG_ENTRY_WIDTH)

// ----------------------------------------
// mesh
`define NOC_NUM_COLUMNS         4
`define NOC_NUM_ROWS            3
`define NOC_NODE_ID_WIDTH       4

// ----------------------------------------
// lbdr layout, routing bits above connectivity bits
`define LBDR_NUM_VNS            3
`define LBDR_ROUTING_BITS       8
`define LBDR_CONNECTIVITY_BITS  4
`define LBDR_BITS_PER_VN        (`LBDR_ROUTING_BITS + `LBDR_CONNECTIVITY_BITS)
`define LBDR_BUS_WIDTH          (`LBDR_BITS_PER_VN * `LBDR_NUM_VNS)

// response queue
`define FILEREG_RESP_WIDTH      (`NOC_NODE_ID_WIDTH + `FILEREG_ENTRY_WIDTH)
`define FILEREG_RESP_DEPTH      2

`endif

//--- filereg_pkg.sv
/*
 * register file types: command encoding, entry index and payload,
 * operation word and response word, plus field positions
 */
`include "filereg_defs.svh"

package filereg_pkg;

  // ----------------------------------------
  // command encoding
  typedef enum logic [`FILEREG_CMD_WIDTH-1:0] {
    CMD_WRITE = 1'b0,
    CMD_READ  = 1'b1
  } filereg_cmd_e;

  // ----------------------------------------
  // vector types
  typedef logic [`FILEREG_ENTRY_ID_WIDTH-1:0] entry_id_t;
  typedef logic [`FILEREG_ENTRY_WIDTH-1:0]    entry_data_t;
  typedef logic [`FILEREG_OP_WIDTH-1:0]       filereg_op_t;
  typedef logic [`FILEREG_RESP_WIDTH-1:0]     filereg_resp_t;

  // field positions inside the operation word
  localparam int OP_DATA_LSB = 0;
  localparam int OP_ID_LSB   = OP_DATA_LSB + `FILEREG_ENTRY_WIDTH;
  localparam int OP_CMD_LSB  = OP_ID_LSB + `FILEREG_ENTRY_ID_WIDTH;

  // field positions inside the response word
  localparam int RESP_DATA_LSB = 0;
  localparam int RESP_NODE_LSB = RESP_DATA_LSB + `FILEREG_ENTRY_WIDTH;

endpackage

//--- lbdr_pkg.sv
/*
 * LBDR types: node id, per-VN bit field and the flat bus
 */
`include "filereg_defs.svh"

package lbdr_pkg;

  // number of nodes in the mesh, ids run row by row
  localparam int NOC_NUM_NODES = `NOC_NUM_COLUMNS * `NOC_NUM_ROWS;

  typedef logic [`NOC_NODE_ID_WIDTH-1:0] node_id_t;

  // ----------------------------------------
  // one VN: {routing[7:0], connectivity[3:0]}
  typedef logic [`LBDR_BITS_PER_VN-1:0] lbdr_vn_bits_t;

  localparam int LBDR_CONN_LSB    = 0;
  localparam int LBDR_ROUTING_LSB = LBDR_CONN_LSB + `LBDR_CONNECTIVITY_BITS;

  // all VNs, VN n in slice n counting from the lsb
  typedef logic [`LBDR_BUS_WIDTH-1:0] lbdr_bus_t;

endpackage

//--- filereg_storage.sv
/*
 * command decode, the 16-entry register array, write and read capture,
 * and the registered LBDR bus for entries 0 to 2
 */
`include "filereg_defs.svh"

module filereg_storage #(
  parameter int unsigned NODE_ID = 0
) (
  input  logic                      clk,
  input  logic                      rst_gen,
  input  logic                      op_tvalid_i,
  input  filereg_pkg::filereg_op_t  op_tdata_i,
  input  logic                      has_space_i,
  output logic                      push_valid_o,
  output filereg_pkg::filereg_resp_t push_data_o,
  output lbdr_pkg::lbdr_bus_t       lbdr_bits_o
);

  import filereg_pkg::*;
  import lbdr_pkg::*;

  // own id as it goes out in every response
  localparam node_id_t OWN_ID = node_id_t'(NODE_ID);

  // the id has to name a node of the mesh
  if (NODE_ID >= NOC_NUM_NODES) begin : g_bad_node_id
    $error("NODE_ID %0d outside the %0d-node mesh", NODE_ID, NOC_NUM_NODES);
  end

  // ----------------------------------------
  // command decode
  filereg_cmd_e op_cmd;
  entry_id_t    op_id;
  entry_data_t  op_payload;
  logic         op_accept;
  logic         wr_en;
  logic         rd_en;

  assign op_cmd     = filereg_cmd_e'(op_tdata_i[OP_CMD_LSB +: `FILEREG_CMD_WIDTH]);
  assign op_id      = op_tdata_i[OP_ID_LSB +: `FILEREG_ENTRY_ID_WIDTH];
  assign op_payload = op_tdata_i[OP_DATA_LSB +: `FILEREG_ENTRY_WIDTH];

  // ready towards the sender is the queue's space flag
  assign op_accept = op_tvalid_i && has_space_i;
  assign wr_en     = op_accept && (op_cmd == CMD_WRITE);
  assign rd_en     = op_accept && (op_cmd == CMD_READ);

  // ----------------------------------------
  // entry array
  entry_data_t entries [`FILEREG_NUM_ENTRIES];

  always_ff @(posedge clk) begin
    if (rst_gen) begin
      for (int i = 0; i < `FILEREG_NUM_ENTRIES; i++) begin
        entries[i] <= '0;
      end
    end else if (wr_en) begin
      entries[op_id] <= op_payload;
    end
  end

  // ----------------------------------------
  // read capture
  // the array is read before the edge updates it, so the snapshot
  // is the value held when the read is accepted
  assign push_valid_o = rd_en;

  always_comb begin
    push_data_o = '0;
    push_data_o[RESP_NODE_LSB +: `NOC_NODE_ID_WIDTH]  = OWN_ID;
    push_data_o[RESP_DATA_LSB +: `FILEREG_ENTRY_WIDTH] = entries[op_id];
  end

  // ----------------------------------------
  // lbdr bus
  // low 12 bits of entries 0..2, one VN each
  lbdr_vn_bits_t vn_bits [`LBDR_NUM_VNS];

  always_comb begin
    for (int vn = 0; vn < `LBDR_NUM_VNS; vn++) begin
      vn_bits[vn] = entries[vn][`LBDR_BITS_PER_VN-1:0];
    end
  end

  // registered, so a write shows up one cycle after its edge
  always_ff @(posedge clk) begin
    if (rst_gen) begin
      lbdr_bits_o <= '0;
    end else begin
      for (int vn = 0; vn < `LBDR_NUM_VNS; vn++) begin
        lbdr_bits_o[vn*`LBDR_BITS_PER_VN +: `LBDR_BITS_PER_VN] <= vn_bits[vn];
      end
    end
  end

endmodule

//--- filereg_resp_fifo.sv
/*
 * response queue: two-slot circular buffer with valid/ready output
 * and a space flag back to the command side
 */
`include "filereg_defs.svh"

module filereg_resp_fifo (
  input  logic                       clk,
  input  logic                       rst_gen,
  input  logic                       push_valid_i,
  input  filereg_pkg::filereg_resp_t push_data_i,
  output logic                       has_space_o,
  output logic                       resp_tvalid_o,
  output filereg_pkg::filereg_resp_t resp_tdata_o,
  input  logic                       resp_tready_i
);

  import filereg_pkg::*;

  localparam int DEPTH   = `FILEREG_RESP_DEPTH;
  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_W = $clog2(DEPTH + 1);

  localparam logic [PTR_W-1:0]   LAST_SLOT = PTR_W'(DEPTH - 1);
  localparam logic [COUNT_W-1:0] FULL      = COUNT_W'(DEPTH);

  // ----------------------------------------
  // storage and pointers
  filereg_resp_t      slots [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [COUNT_W-1:0] count;

  logic push;
  logic pop;

  assign has_space_o   = (count != FULL);
  assign resp_tvalid_o = (count != '0);
  assign resp_tdata_o  = slots[rd_ptr];

  // push only into a free slot, pop only what the consumer takes
  assign push = push_valid_i && has_space_o;
  assign pop  = resp_tvalid_o && resp_tready_i;

  // snapshots stay put until popped
  always_ff @(posedge clk) begin
    if (push) begin
      slots[wr_ptr] <= push_data_i;
    end
  end

  // ----------------------------------------
  // control
  always_ff @(posedge clk) begin
    if (rst_gen) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count as it is
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- filereg_top.sv
/*
 * router node configuration register file: storage plus
 * response queue, command and response streams on valid/ready
 */

module filereg_top #(
  // x=1, y=1 on a 4-column mesh
  parameter int unsigned NODE_ID = 5
) (
  input  logic                       clk,
  input  logic                       rst_gen,

  // command stream
  input  logic                       op_tvalid_i,
  input  filereg_pkg::filereg_op_t   op_tdata_i,
  output logic                       op_tready_o,

  // response stream
  output logic                       resp_tvalid_o,
  output filereg_pkg::filereg_resp_t resp_tdata_o,
  input  logic                       resp_tready_i,

  // per-VN routing and connectivity bits
  output lbdr_pkg::lbdr_bus_t        lbdr_bits_o
);

  import filereg_pkg::*;

  // ----------------------------------------
  // storage to queue
  logic          push_valid;
  filereg_resp_t push_data;
  logic          has_space;

  // a full queue stalls writes too, keeps commands in order
  assign op_tready_o = has_space;

  filereg_storage #(
    .NODE_ID (NODE_ID)
  ) u_storage (
    .clk          (clk),
    .rst_gen      (rst_gen),
    .op_tvalid_i  (op_tvalid_i),
    .op_tdata_i   (op_tdata_i),
    .has_space_i  (has_space),
    .push_valid_o (push_valid),
    .push_data_o  (push_data),
    .lbdr_bits_o  (lbdr_bits_o)
  );

  // ----------------------------------------
  // response queue
  filereg_resp_fifo u_resp_fifo (
    .clk           (clk),
    .rst_gen       (rst_gen),
    .push_valid_i  (push_valid),
    .push_data_i   (push_data),
    .has_space_o   (has_space),
    .resp_tvalid_o (resp_tvalid_o),
    .resp_tdata_o  (resp_tdata_o),
    .resp_tready_i (resp_tready_i)
  );

endmodule

//--- tb_clock_gen.sv
/*
 * free-running testbench clock, starts low
 */

module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

//--- tb_filereg_sva.sv
/*
 * concurrent assertions on the command and response handshakes,
 * bound into filereg_top
 */

module tb_filereg_sva (
  input logic                       clk,
  input logic                       rst_gen,
  input logic                       op_tvalid_i,
  input filereg_pkg::filereg_op_t   op_tdata_i,
  input logic                       op_tready_o,
  input logic                       resp_tvalid_o,
  input filereg_pkg::filereg_resp_t resp_tdata_o,
  input logic                       resp_tready_i
);

  // ----------------------------------------
  // command side, the sender holds a stalled word
  op_hold_a : assert property (@(posedge clk) disable iff (rst_gen)
    op_tvalid_i && !op_tready_o |=> op_tvalid_i && $stable(op_tdata_i))
    else $error("command word dropped or changed while stalled");

  // response side, the queue head stays put until taken
  resp_hold_a : assert property (@(posedge clk) disable iff (rst_gen)
    resp_tvalid_o && !resp_tready_i |=> resp_tvalid_o && $stable(resp_tdata_o))
    else $error("response dropped or changed while stalled");

  // ----------------------------------------
  // queue empty once reset has been seen
  resp_reset_a : assert property (@(posedge clk)
    rst_gen |=> !resp_tvalid_o)
    else $error("response valid high during reset");

endmodule

bind filereg_top tb_filereg_sva u_handshake_sva (
  .clk           (clk),
  .rst_gen       (rst_gen),
  .op_tvalid_i   (op_tvalid_i),
  .op_tdata_i    (op_tdata_i),
  .op_tready_o   (op_tready_o),
  .resp_tvalid_o (resp_tvalid_o),
  .resp_tdata_o  (resp_tdata_o),
  .resp_tready_i (resp_tready_i)
);

//--- tb_filereg.sv
/*
 * testbench for the router node register file: reference model,
 * directed tests, random traffic and the closing summary
 */
`include "filereg_defs.svh"

module tb_filereg;

  import filereg_pkg::*;
  import lbdr_pkg::*;

  localparam int unsigned NODE_ID      = 5;
  localparam node_id_t    NODE_TAG     = node_id_t'(NODE_ID);
  localparam int          OP_TIMEOUT   = 100;
  localparam int          DRAIN_TIMEOUT = 200;

  logic          clk;
  logic          rst_gen;
  logic          op_tvalid_i;
  filereg_op_t   op_tdata_i;
  logic          op_tready_o;
  logic          resp_tvalid_o;
  filereg_resp_t resp_tdata_o;
  logic          resp_tready_i;
  lbdr_bus_t     lbdr_bits_o;

  // ----------------------------------------
  // reference model and bookkeeping
  entry_data_t   ref_mem [`FILEREG_NUM_ENTRIES];
  filereg_resp_t exp_q [$];
  filereg_cmd_e  cur_cmd;
  entry_id_t     cur_id;
  entry_data_t   cur_data;
  logic          rand_ready;
  integer        seed;
  int            err_count;
  int            check_count;
  int            test_count;
  int            resp_count;

  tb_clock_gen #(.PERIOD(40)) u_clock (.clk_o(clk));

  filereg_top #(
    .NODE_ID (NODE_ID)
  ) UUT (
    .clk           (clk),
    .rst_gen       (rst_gen),
    .op_tvalid_i   (op_tvalid_i),
    .op_tdata_i    (op_tdata_i),
    .op_tready_o   (op_tready_o),
    .resp_tvalid_o (resp_tvalid_o),
    .resp_tdata_o  (resp_tdata_o),
    .resp_tready_i (resp_tready_i),
    .lbdr_bits_o   (lbdr_bits_o)
  );

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, actual, expected);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    $display("test %s: %s", name, (err_count == errs_before) ? "ok" : "errors found");
  endtask

  // ----------------------------------------
  // one clock, entered and left 2 units after the edge
  // handshakes are sampled before the edge where they are stable
  task automatic step_cycle(output logic op_fired);
    integer        rnd;
    filereg_resp_t expected;
    if (rand_ready) begin
      rnd = $random(seed);
      resp_tready_i = rnd[0];
    end
    #1;
    op_fired = op_tvalid_i && op_tready_o;
    if (resp_tvalid_o && resp_tready_i) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t: response seen with no read outstanding", $time);
        err_count++;
      end else begin
        expected = exp_q.pop_front();
        check_value("resp_tdata_o", 64'(resp_tdata_o), 64'(expected));
        resp_count++;
      end
    end
    // a read snapshots the entry before a write could change it
    if (op_fired) begin
      if (cur_cmd == CMD_WRITE) begin
        ref_mem[cur_id] = cur_data;
      end else begin
        exp_q.push_back({NODE_TAG, ref_mem[cur_id]});
      end
    end
    @(posedge clk);
    #2;
  endtask

  task automatic send_op(input filereg_cmd_e cmd, input entry_id_t id, input entry_data_t data);
    logic fired;
    int   waited;
    cur_cmd     = cmd;
    cur_id      = id;
    cur_data    = data;
    op_tvalid_i = 1'b1;
    op_tdata_i  = {cmd, id, data};
    fired       = 1'b0;
    waited      = 0;
    while (!fired && waited < OP_TIMEOUT) begin
      step_cycle(fired);
      waited++;
    end
    op_tvalid_i = 1'b0;
    if (!fired) begin
      $display("error at %0t: command for entry %0d not accepted within %0d cycles",
               $time, id, OP_TIMEOUT);
      err_count++;
    end
  endtask

  task automatic drain_responses();
    logic fired;
    int   waited;
    rand_ready    = 1'b0;
    resp_tready_i = 1'b1;
    waited        = 0;
    while ((exp_q.size() != 0 || resp_tvalid_o) && waited < DRAIN_TIMEOUT) begin
      step_cycle(fired);
      waited++;
    end
    if (exp_q.size() != 0 || resp_tvalid_o) begin
      $display("error at %0t: %0d responses still missing after %0d cycles",
               $time, exp_q.size(), DRAIN_TIMEOUT);
      err_count++;
    end
  endtask

  task automatic apply_reset();
    rst_gen = 1'b1;
    foreach (ref_mem[i]) begin
      ref_mem[i] = '0;
    end
    exp_q.delete();
    repeat (4) @(posedge clk);
    #2;
    rst_gen = 1'b0;
  endtask

  // ----------------------------------------
  // directed tests
  task automatic reset_state_test();
    int errs;
    errs = err_count;
    check_value("resp_tvalid_o", 64'(resp_tvalid_o), 64'd0);
    check_value("op_tready_o", 64'(op_tready_o), 64'd1);
    check_value("lbdr_bits_o", 64'(lbdr_bits_o), 64'd0);
    report_test("reset_state", errs);
  endtask

  task automatic lbdr_bus_test();
    int          errs;
    logic        fired;
    entry_data_t words [`LBDR_NUM_VNS];
    errs     = err_count;
    words[0] = 32'h1234_5ABC;
    words[1] = 32'hFFFF_F0F0;
    words[2] = 32'h0000_0963;
    for (int vn = 0; vn < `LBDR_NUM_VNS; vn++) begin
      send_op(CMD_WRITE, entry_id_t'(vn), words[vn]);
    end
    // bus is registered, one more cycle
    step_cycle(fired);
    for (int vn = 0; vn < `LBDR_NUM_VNS; vn++) begin
      check_value($sformatf("lbdr_bits_o vn%0d", vn),
                  64'(lbdr_bits_o[vn*`LBDR_BITS_PER_VN +: `LBDR_BITS_PER_VN]),
                  64'(words[vn][`LBDR_BITS_PER_VN-1:0]));
    end
    report_test("lbdr_bus", errs);
  endtask

  task automatic write_read_test();
    int errs;
    int start;
    errs = err_count;
    for (int i = 0; i < `FILEREG_NUM_ENTRIES; i++) begin
      send_op(CMD_WRITE, entry_id_t'(i), entry_data_t'((i + 1) * 32'h0101_0101) ^ 32'h5A3C_00F0);
    end
    resp_tready_i = 1'b1;
    start         = resp_count;
    for (int i = 0; i < `FILEREG_NUM_ENTRIES; i++) begin
      send_op(CMD_READ, entry_id_t'(i), '0);
    end
    drain_responses();
    check_value("response count", 64'(resp_count - start), 64'(`FILEREG_NUM_ENTRIES));
    report_test("write_read", errs);
  endtask

  task automatic snapshot_test();
    int errs;
    errs          = err_count;
    resp_tready_i = 1'b0;
    // old value queued, then overwritten, then read again
    send_op(CMD_READ, 4'd10, '0);
    send_op(CMD_WRITE, 4'd10, 32'hDEAD_0A0A);
    send_op(CMD_READ, 4'd10, '0);
    check_value("op_tready_o", 64'(op_tready_o), 64'd0);
    check_value("resp_tvalid_o", 64'(resp_tvalid_o), 64'd1);
    drain_responses();
    report_test("snapshot", errs);
  endtask

  task automatic random_traffic_test();
    int           errs;
    integer       rnd;
    filereg_cmd_e cmd;
    entry_data_t  data;
    errs       = err_count;
    seed       = 15;
    rand_ready = 1'b1;
    for (int n = 0; n < 200; n++) begin
      rnd  = $random(seed);
      cmd  = rnd[0] ? CMD_READ : CMD_WRITE;
      data = $random(seed);
      send_op(cmd, rnd[7:4], data);
    end
    drain_responses();
    report_test("random_traffic", errs);
  endtask

  // ----------------------------------------
  // main sequence
  initial begin
    rst_gen       = 1'b1;
    op_tvalid_i   = 1'b0;
    op_tdata_i    = '0;
    resp_tready_i = 1'b0;
    rand_ready    = 1'b0;
    cur_cmd       = CMD_WRITE;
    cur_id        = '0;
    cur_data      = '0;
    seed          = 15;
    err_count     = 0;
    check_count   = 0;
    test_count    = 0;
    resp_count    = 0;

    apply_reset();
    reset_state_test();
    lbdr_bus_test();
    write_read_test();
    snapshot_test();
    random_traffic_test();

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
filereg_pkg.sv
lbdr_pkg.sv
filereg_storage.sv
filereg_resp_fifo.sv
filereg_top.sv
tb_clock_gen.sv
tb_filereg_sva.sv
tb_filereg.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the register file testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_filereg
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_filereg)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# pass only if the testbench printed its pass line
if echo "$output" | grep -qx "Simulation PASSED"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
